// ==== sim.f ====
design/bnnPkg.sv
design/featureFifo.sv
design/hiddenLayer.sv
design/outputLayer.sv
design/classSelect.sv
design/bnnClassifier.sv
testbench/bnnClassifier_properties.sv
testbench/bnnClassifierTb.sv

// ==== Bender.yml ====
package:
  name: bnn_classifier

sources:
  - files:
      - design/bnnPkg.sv
      - design/featureFifo.sv
      - design/hiddenLayer.sv
      - design/outputLayer.sv
      - design/classSelect.sv
      - design/bnnClassifier.sv
  - target: simulation
    files:
      - testbench/bnnClassifier_properties.sv
      - testbench/bnnClassifierTb.sv

// ==== testbench/bnnClassifierTb.sv ====
`timescale 1ns/1ns

module bnnClassifierTb;
  import bnnPkg::*;

  localparam int NumRows = 14;
  localparam int TimeoutCycles = NumRows * 60 + 400;  // Margin covers credit delays

  typedef struct packed {
    featureVec_t sample;
    logic [7:0] creditDelay;
    classResult_t expected;
  } row_t;

  logic clk;
  logic rst;
  logic inValid;
  featureVec_t inSample;
  logic inCredit;
  logic outValid;
  classResult_t outResult;
  logic outCredit;

  row_t stimTable [NumRows];
  logic [15:0] lfsr = 16'd15;
  int gotCount = 0;
  int creditPulses = 0;
  int sentCount = 0;
  int heldResults = 0;
  int creditQ [$];

  bnnClassifier DUT (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inSample(inSample),
    .inCredit(inCredit),
    .outValid(outValid),
    .outResult(outResult),
    .outCredit(outCredit)
  );

  always #20 clk = ~clk;

  function automatic logic lfsrBit();
    lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;  // Taps 16,14,13,11
    return lfsr[0];
  endfunction

  function automatic featureVec_t randomSample();
    featureVec_t s;
    for (int f = 0; f < NumFeatures; f++) begin
      for (int b = 0; b < FeatureBits; b++) begin
        s[f][b] = lfsrBit();
      end
    end
    return s;
  endfunction

  // Whole network on one sample
  function automatic classResult_t referenceClass(input featureVec_t s, output logic tied);
    int sum;
    int counts [NumClasses];
    int best;
    hiddenVec_t hv;
    for (int n = 0; n < NumHidden; n++) begin
      sum = 0;
      for (int f = 0; f < NumFeatures; f++) begin
        if (HiddenWeights[f * NumHidden + n]) sum += int'(s[f]);
        else sum -= int'(s[f]);
      end
      hv[n] = sum >= 0;
    end
    best = 0;
    tied = 1'b0;
    for (int c = 0; c < NumClasses; c++) begin
      counts[c] = 0;
      for (int h = 0; h < NumHidden; h++) begin
        if (hv[h] == OutputWeights[c * NumHidden + h]) counts[c]++;
      end
      if (counts[c] > counts[best]) best = c;
    end
    for (int c = best + 1; c < NumClasses; c++) begin
      if (counts[c] == counts[best]) tied = 1'b1;  // A later class matches the best
    end
    return {classId_t'(best), score_t'(counts[best])};
  endfunction

  task automatic stopWithFail(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stopWithFail($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic buildTable();
    featureVec_t s;
    logic tied;
    logic found;
    for (int i = 0; i < NumRows; i++) begin
      case (i)
        0: s = '0;
        1: s = {NumFeatures{4'hF}};
        11: begin  // Search for a sample whose best count is shared
          found = 1'b0;
          for (int t = 0; t < 5000 && !found; t++) begin
            s = randomSample();
            void'(referenceClass(s, tied));
            found = tied;
          end
          if (!found) stopWithFail("No sample with tied class counts was found");
        end
        13: s = 44'h123_4567_89AB;
        default: s = randomSample();
      endcase
      stimTable[i].sample = s;
      stimTable[i].creditDelay = (i == 8) ? 8'd150 : (i == 12) ? 8'd3 : 8'd0;
      stimTable[i].expected = referenceClass(s, tied);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    inSample = '0;
    outCredit = 1'b0;
    buildTable();
    repeat (4) @(posedge clk);
    #2 rst = 1'b0;
  end

  initial begin : sender
    int credits;
    int idx;
    credits = FifoDepth;
    idx = 0;
    @(negedge rst);
    while (idx < NumRows) begin
      @(posedge clk);
      #2;
      if (inCredit) credits++;
      if (credits > 0) begin
        inValid = 1'b1;
        inSample = stimTable[idx].sample;
        credits--;
        idx++;
      end else begin
        inValid = 1'b0;  // Starved until a credit returns
      end
    end
    @(posedge clk);
    #2 inValid = 1'b0;
  end

  initial begin : creditReturn
    int delay;
    @(negedge rst);
    forever begin
      @(posedge clk);
      if (creditQ.size() > 0) begin
        delay = creditQ.pop_front();
        repeat (delay) @(posedge clk);
        #2 outCredit = 1'b1;
        @(posedge clk);
        #2 outCredit = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (inCredit) creditPulses++;
      if (inValid) begin
        sentCount++;
        if (sentCount > FifoDepth + creditPulses) begin
          stopWithFail("Sender used more credits than were granted");
        end
      end
      if (creditPulses > sentCount) begin
        stopWithFail("Input credit returned for a sample that was never sent");
      end
      if (outCredit) heldResults--;
      if (outValid) begin
        if (gotCount >= NumRows) stopWithFail("DUT produced a result that was never sent");
        checkValue("outResult.classId", outResult.classId, stimTable[gotCount].expected.classId);
        checkValue("outResult.score", outResult.score, stimTable[gotCount].expected.score);
        creditQ.push_back(stimTable[gotCount].creditDelay);
        gotCount++;
        heldResults++;
        if (heldResults > OutCredits) stopWithFail("More results arrived than output credits");
      end
    end
  end

  initial begin : watchdog
    repeat (TimeoutCycles) @(posedge clk);
    stopWithFail("Timeout, not every result came back");
  end

  initial begin : finishRun
    @(negedge rst);
    wait (gotCount == NumRows);
    repeat (60) @(posedge clk);  // Room for a stray extra result
    if (creditPulses == NumRows && sentCount == NumRows) begin
      $display("** PASS **");
      $finish;
    end else begin
      stopWithFail($sformatf("Credit pulses %0d and sends %0d do not match %0d samples",
        creditPulses, sentCount, NumRows));
    end
  end

endmodule

// ==== testbench/bnnClassifier_properties.sv ====
`timescale 1ns/1ns

module bnnClassifierProperties (
  input logic clk,
  input logic rst,
  input logic inValid,
  input logic inCredit,
  input logic outValid,
  input bnnPkg::classResult_t outResult,
  input bnnPkg::fifoCount_t fifoCount
);
  import bnnPkg::*;

  noOverflow: assert property (@(posedge clk) disable iff (rst)
    inValid |-> fifoCount < FifoDepth)
    else $error("inValid seen while the input FIFO is full");

  creditPulse: assert property (@(posedge clk) disable iff (rst)
    inCredit |=> !inCredit)
    else $error("inCredit held longer than one cycle");

  validPulse: assert property (@(posedge clk) disable iff (rst)
    outValid |=> !outValid)
    else $error("outValid held longer than one cycle");

  // Result must not move right after it is presented
  resultStable: assert property (@(posedge clk) disable iff (rst)
    outValid |=> $stable(outResult))
    else $error("outResult changed while it was being delivered");

endmodule

bind bnnClassifier bnnClassifierProperties props (
  .clk(clk),
  .rst(rst),
  .inValid(inValid),
  .inCredit(inCredit),
  .outValid(outValid),
  .outResult(outResult),
  .fifoCount(fifo.count)
);

// ==== design/bnnClassifier.sv ====
`timescale 1ns/1ns

module bnnClassifier (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  bnnPkg::featureVec_t inSample,
  output logic inCredit,
  output logic outValid,
  output bnnPkg::classResult_t outResult,
  input  logic outCredit
);
  import bnnPkg::*;

  logic sampleValid;
  featureVec_t sample;
  logic sampleTake;
  logic hiddenValid;
  hiddenVec_t hidden;
  logic hiddenTake;
  logic sumsValid;
  classSums_t sums;
  logic sumsTake;

  featureFifo fifo (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inSample(inSample),
    .inCredit(inCredit),
    .sampleValid(sampleValid),
    .sample(sample),
    .sampleTake(sampleTake)
  );

  hiddenLayer layer1 (
    .clk(clk),
    .rst(rst),
    .sampleValid(sampleValid),
    .sample(sample),
    .sampleTake(sampleTake),
    .hiddenValid(hiddenValid),
    .hidden(hidden),
    .hiddenTake(hiddenTake)
  );

  outputLayer layer2 (
    .clk(clk),
    .rst(rst),
    .hiddenValid(hiddenValid),
    .hidden(hidden),
    .hiddenTake(hiddenTake),
    .sumsValid(sumsValid),
    .sums(sums),
    .sumsTake(sumsTake)
  );

  classSelect select (
    .clk(clk),
    .rst(rst),
    .sumsValid(sumsValid),
    .sums(sums),
    .sumsTake(sumsTake),
    .outValid(outValid),
    .outResult(outResult),
    .outCredit(outCredit)
  );

endmodule

// ==== design/classSelect.sv ====
`timescale 1ns/1ns

module classSelect (
  input  logic clk,
  input  logic rst,
  input  logic sumsValid,
  input  bnnPkg::classSums_t sums,
  output logic sumsTake,
  output logic outValid,
  output bnnPkg::classResult_t outResult,
  input  logic outCredit
);
  import bnnPkg::*;

  classId_t bestId;
  score_t bestScore;
  creditCnt_t credits;

  assign sumsTake = sumsValid && credits != '0;

  // Strictly greater wins, so ties keep the lowest index
  always_comb begin
    bestId = '0;
    bestScore = sums[0];
    for (int c = 1; c < NumClasses; c++) begin
      if (sums[c] > bestScore) begin
        bestId = classId_t'(c);
        bestScore = sums[c];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      outValid <= 1'b0;
      credits <= creditCnt_t'(OutCredits);
    end else begin
      outValid <= sumsTake;  // Single cycle per result
      case ({sumsTake, outCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // Spend and refund cancel
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sumsTake) begin
      outResult.classId <= bestId;
      outResult.score <= bestScore;
    end
  end

endmodule

// ==== design/outputLayer.sv ====
`timescale 1ns/1ns

module outputLayer (
  input  logic clk,
  input  logic rst,
  input  logic hiddenValid,
  input  bnnPkg::hiddenVec_t hidden,
  output logic hiddenTake,
  output logic sumsValid,
  output bnnPkg::classSums_t sums,
  input  logic sumsTake
);
  import bnnPkg::*;

  typedef enum logic [1:0] {Idle, Busy, Full} state_t;

  state_t state;
  hiddenVec_t hiddenReg;
  hiddenIdx_t bitIdx;
  logic lastBit;
  logic curBit;

  assign hiddenTake = hiddenValid && state == Idle;
  assign sumsValid = state == Full;
  assign lastBit = bitIdx == hiddenIdx_t'(NumHidden - 1);
  assign curBit = hiddenReg[bitIdx];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= Idle;
      bitIdx <= '0;
    end else begin
      case (state)
        Idle: if (hiddenTake) state <= Busy;
        Busy: begin
          bitIdx <= lastBit ? '0 : bitIdx + 1'b1;
          if (lastBit) state <= Full;
        end
        Full: if (sumsTake) state <= Idle;
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (hiddenTake) hiddenReg <= hidden;
  end

  // Counts stay put while Full and serve as the sums
  for (genvar c = 0; c < NumClasses; c++) begin : gClass
    score_t count;
    logic agree;

    assign agree = curBit == OutputWeights[c * NumHidden + bitIdx];  // XNOR
    assign sums[c] = count;

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        count <= '0;
      end else if (hiddenTake) begin
        count <= '0;
      end else if (state == Busy) begin
        count <= count + score_t'(agree);
      end
    end
  end

endmodule

// ==== design/hiddenLayer.sv ====
`timescale 1ns/1ns

module hiddenLayer (
  input  logic clk,
  input  logic rst,
  input  logic sampleValid,
  input  bnnPkg::featureVec_t sample,
  output logic sampleTake,
  output logic hiddenValid,
  output bnnPkg::hiddenVec_t hidden,
  input  logic hiddenTake
);
  import bnnPkg::*;

  typedef enum logic [1:0] {Idle, Busy, Full} state_t;

  state_t state;
  featureVec_t sampleReg;
  featIdx_t featIdx;
  feature_t curFeature;
  neuronAcc_t curTerm;
  hiddenVec_t signBits;
  logic lastFeature;
  logic slotFree;

  assign hiddenValid = state == Full;
  // Next sample may enter as the held result leaves
  assign slotFree = (state == Idle) || (state == Full && hiddenTake);
  assign sampleTake = sampleValid && slotFree;
  assign lastFeature = featIdx == featIdx_t'(NumFeatures - 1);
  assign curFeature = sampleReg[featIdx];
  assign curTerm = neuronAcc_t'(curFeature);  // Unsigned, zero extended

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= Idle;
      featIdx <= '0;
    end else begin
      case (state)
        Idle: if (sampleTake) state <= Busy;
        Busy: begin
          featIdx <= lastFeature ? '0 : featIdx + 1'b1;
          if (lastFeature) state <= Full;
        end
        Full: if (hiddenTake) state <= sampleTake ? Busy : Idle;
        default: state <= Idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sampleTake) sampleReg <= sample;
    if (state == Busy && lastFeature) hidden <= signBits;
  end

  for (genvar n = 0; n < NumHidden; n++) begin : gNeuron
    neuronAcc_t acc;
    neuronAcc_t nextAcc;
    logic addBit;

    assign addBit = HiddenWeights[featIdx * NumHidden + n];
    assign nextAcc = addBit ? acc + curTerm : acc - curTerm;
    assign signBits[n] = ~nextAcc[NeuronBits-1];  // Sum >= 0

    always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
        acc <= '0;
      end else if (state == Busy) begin
        acc <= lastFeature ? '0 : nextAcc;
      end
    end
  end

endmodule

// ==== design/featureFifo.sv ====
`timescale 1ns/1ns

module featureFifo (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  bnnPkg::featureVec_t inSample,
  output logic inCredit,
  output logic sampleValid,
  output bnnPkg::featureVec_t sample,
  input  logic sampleTake
);
  import bnnPkg::*;

  featureVec_t mem [FifoDepth];
  fifoPtr_t wrPtr;
  fifoPtr_t rdPtr;
  fifoCount_t count;
  logic push;
  logic pop;

  assign push = inValid;  // Sender only sends with a credit
  assign pop = sampleTake && sampleValid;
  assign sampleValid = count != '0;
  assign sample = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inSample;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      inCredit <= 1'b0;
    end else begin
      inCredit <= pop;  // One credit back per pop
      if (push) begin
        wrPtr <= (wrPtr == fifoPtr_t'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == fifoPtr_t'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/bnnPkg.sv ====
package bnnPkg;

  localparam int NumFeatures = 11;
  localparam int FeatureBits = 4;
  localparam int NumHidden = 40;
  localparam int NumClasses = 7;
  localparam int FifoDepth = 2;
  localparam int OutCredits = 2;

  localparam int NeuronBits = 9;  // Holds +-165 with sign
  localparam int ScoreBits = 6;   // Popcount 0..40
  localparam int ClassBits = 3;

  // Bit f*NumHidden+n set means neuron n adds feature f
  localparam logic [NumFeatures*NumHidden-1:0] HiddenWeights = {
    160'h5B25663F_86E7BDE8_30A6F10C_B3957448_E2B54E5D,
    160'hEB3BE336_B67C83CD_2685A1FE_E248F0A5_D8A8F7E5,
    120'hCB172127_28C004B5_1AB89C4A_FE0E58
  };

  // Bit c*NumHidden+h set means a hidden 1 agrees with class c
  localparam logic [NumClasses*NumHidden-1:0] OutputWeights = {
    160'h6B7AD953_00E777F8_D1B0EB72_F0D7B0CB_423057B0,
    120'hEB72F8D7_D8EB72FC_C7B1E353_4CC073
  };

  typedef logic [FeatureBits-1:0] feature_t;
  typedef logic signed [NeuronBits-1:0] neuronAcc_t;
  typedef logic [ScoreBits-1:0] score_t;
  typedef logic [ClassBits-1:0] classId_t;
  typedef logic [NumHidden-1:0] hiddenVec_t;

  typedef logic [$clog2(FifoDepth)-1:0] fifoPtr_t;
  typedef logic [$clog2(FifoDepth+1)-1:0] fifoCount_t;
  typedef logic [$clog2(OutCredits+1)-1:0] creditCnt_t;
  typedef logic [$clog2(NumFeatures)-1:0] featIdx_t;
  typedef logic [$clog2(NumHidden)-1:0] hiddenIdx_t;

  typedef feature_t [NumFeatures-1:0] featureVec_t;  // Feature 0 in low bits
  typedef score_t [NumClasses-1:0] classSums_t;

  typedef struct packed {
    classId_t classId;
    score_t score;
  } classResult_t;

endpackage
